// ==== run_sim.sh ====
#!/bin/sh
# Builds the matrix game testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_matrix_game -f verilog.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_matrix_game)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

// ==== source/background_scroller.sv ====
/* Eight-row obstacle field, scrolls down on each step */
`timescale 1ns/1ps

module background_scroller (
	input  logic clock_50,
	input  logic reset,
	input  logic start_pulse,
	input  logic step,
	input  matrix_game_pkg::row_t new_row,
	output matrix_game_pkg::row_t row_0,
	output matrix_game_pkg::row_t row_1,
	output matrix_game_pkg::row_t row_2,
	output matrix_game_pkg::row_t row_3,
	output matrix_game_pkg::row_t row_4,
	output matrix_game_pkg::row_t row_5,
	output matrix_game_pkg::row_t row_6,
	output matrix_game_pkg::row_t row_7
);

	// Row 0 is the player row, row 7 the top
	matrix_game_pkg::row_t field [matrix_game_pkg::ROW_COUNT];

	always_ff @(posedge clock_50) begin
		if (reset || start_pulse) begin
			for (int k = 0; k < matrix_game_pkg::ROW_COUNT; k++) begin
				field[k] <= '0;
			end
		end else if (step) begin
			// Everything moves one row down, new obstacles enter on top
			for (int k = 0; k < matrix_game_pkg::ROW_COUNT - 1; k++) begin
				field[k] <= field[k + 1];
			end
			field[matrix_game_pkg::ROW_COUNT - 1] <= new_row;
		end
	end

	assign row_0 = field[0];
	assign row_1 = field[1];
	assign row_2 = field[2];
	assign row_3 = field[3];
	assign row_4 = field[4];
	assign row_5 = field[5];
	assign row_6 = field[6];
	assign row_7 = field[7];

endmodule

// ==== source/matrix_game_pkg.sv ====
/* Widths, vector types and state enums of the matrix game,
   step and serial timing constants and MAX7219 configuration words */
package matrix_game_pkg;

	// One player's half row, also used for the one-hot player marker
	typedef logic [3:0] half_row_t;
	// Full matrix row, upper nibble belongs to the left player
	typedef logic [7:0] row_t;
	typedef logic [2:0] row_index_t;
	// Serial word: 4 zero bits, register address, data byte
	typedef logic [15:0] max_word_t;

	typedef enum logic {game_idle, game_running} game_state_t;
	typedef enum logic [1:0] {max_config, max_scan, max_gap} max_state_t;

	localparam int ROW_COUNT = 8;
	localparam half_row_t START_POSITION = 4'b0010;

	// Game speed in clock cycles per step
	localparam int STEP_CYCLES = 4096;

	// Serial timing of the display link
	localparam int SERIAL_HALF_PERIOD = 2;
	localparam int GAP_CYCLES = 4;

	localparam logic [15:0] LFSR_SEED = 16'hACE1;

	// Configuration words, sent once after reset in this order
	localparam int CONFIG_WORDS = 5;
	localparam max_word_t CONFIG_SHUTDOWN = 16'h0C01;
	localparam max_word_t CONFIG_SCAN_LIMIT = 16'h0B07;
	localparam max_word_t CONFIG_DECODE = 16'h0900;
	localparam max_word_t CONFIG_INTENSITY = 16'h0A0A;
	localparam max_word_t CONFIG_TEST = 16'h0F00;

endpackage

// ==== source/matrix_game_top.sv ====
/* Top of the two-player matrix game: timer, players, obstacles,
   field and display driver, with the row-0 frame composition */
`timescale 1ns/1ps

module matrix_game_top (
	input  logic clock_50,
	input  logic reset,
	input  logic start_button,
	input  logic left_button_l,
	input  logic right_button_l,
	input  logic left_button_r,
	input  logic right_button_r,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);

	logic start_pulse;
	logic running;
	logic step;
	matrix_game_pkg::half_row_t position_l;
	matrix_game_pkg::half_row_t position_r;
	matrix_game_pkg::row_t new_row;
	matrix_game_pkg::row_t background [matrix_game_pkg::ROW_COUNT];
	matrix_game_pkg::row_t player_row;

	// ##########################################################
	// Game control and players
	// ##########################################################
	step_timer i_step_timer (
		.clock_50    (clock_50),
		.reset       (reset),
		.start_button(start_button),
		.start_pulse (start_pulse),
		.running     (running),
		.step        (step)
	);

	// Left player owns the upper nibble
	player_position i_player_l (
		.clock_50   (clock_50),
		.reset      (reset),
		.start_pulse(start_pulse),
		.running    (running),
		.move_left  (left_button_l),
		.move_right (right_button_l),
		.position   (position_l)
	);

	player_position i_player_r (
		.clock_50   (clock_50),
		.reset      (reset),
		.start_pulse(start_pulse),
		.running    (running),
		.move_left  (left_button_r),
		.move_right (right_button_r),
		.position   (position_r)
	);

	// ##########################################################
	// Obstacle field
	// ##########################################################
	obstacle_source i_obstacle_source (
		.clock_50(clock_50),
		.reset   (reset),
		.step    (step),
		.new_row (new_row)
	);

	background_scroller i_background_scroller (
		.clock_50   (clock_50),
		.reset      (reset),
		.start_pulse(start_pulse),
		.step       (step),
		.new_row    (new_row),
		.row_0      (background[0]),
		.row_1      (background[1]),
		.row_2      (background[2]),
		.row_3      (background[3]),
		.row_4      (background[4]),
		.row_5      (background[5]),
		.row_6      (background[6]),
		.row_7      (background[7])
	);

	// ##########################################################
	// Display
	// ##########################################################
	// Markers overlay the bottom row of the field
	assign player_row = background[0] | {position_l, position_r};

	max7219_driver i_max7219_driver (
		.clock_50   (clock_50),
		.reset      (reset),
		.frame_0    (player_row),
		.frame_1    (background[1]),
		.frame_2    (background[2]),
		.frame_3    (background[3]),
		.frame_4    (background[4]),
		.frame_5    (background[5]),
		.frame_6    (background[6]),
		.frame_7    (background[7]),
		.max7219_din(max7219_din),
		.max7219_ncs(max7219_ncs),
		.max7219_clk(max7219_clk)
	);

endmodule

// ==== source/max7219_driver.sv ====
/* MAX7219 link: frame snapshot, column words, configuration sequence,
   serial shifter with clock divider and chip-select gap */
`timescale 1ns/1ps

module max7219_driver (
	input  logic clock_50,
	input  logic reset,
	input  matrix_game_pkg::row_t frame_0,
	input  matrix_game_pkg::row_t frame_1,
	input  matrix_game_pkg::row_t frame_2,
	input  matrix_game_pkg::row_t frame_3,
	input  matrix_game_pkg::row_t frame_4,
	input  matrix_game_pkg::row_t frame_5,
	input  matrix_game_pkg::row_t frame_6,
	input  matrix_game_pkg::row_t frame_7,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);

	matrix_game_pkg::max_state_t state;
	matrix_game_pkg::row_t live [matrix_game_pkg::ROW_COUNT];
	matrix_game_pkg::row_t snapshot [matrix_game_pkg::ROW_COUNT];
	matrix_game_pkg::row_t view [matrix_game_pkg::ROW_COUNT];
	matrix_game_pkg::row_t column;
	matrix_game_pkg::row_index_t word_index;
	matrix_game_pkg::row_index_t column_index;
	matrix_game_pkg::max_word_t next_word;
	matrix_game_pkg::max_word_t shifter;
	logic [3:0] digit_addr;
	logic [3:0] bit_count;
	logic [$clog2(matrix_game_pkg::SERIAL_HALF_PERIOD)-1:0] half_count;
	logic [$clog2(matrix_game_pkg::GAP_CYCLES)-1:0] gap_count;
	logic config_done;
	logic half_done;
	logic gap_done;

	// ##########################################################
	// Word selection
	// ##########################################################
	assign live = '{frame_0, frame_1, frame_2, frame_3,
		frame_4, frame_5, frame_6, frame_7};

	// Digit 1 loads together with the snapshot, so it reads the live frame
	always_comb begin
		for (int r = 0; r < matrix_game_pkg::ROW_COUNT; r++) begin
			view[r] = (word_index == '0) ? live[r] : snapshot[r];
		end
	end

	// Digit d shows column 8-d, row 0 goes to data bit 7
	assign column_index = 3'd7 - word_index;
	assign digit_addr = {1'b0, word_index} + 4'd1;

	always_comb begin
		for (int r = 0; r < matrix_game_pkg::ROW_COUNT; r++) begin
			column[matrix_game_pkg::ROW_COUNT - 1 - r] = view[r][column_index];
		end
	end

	always_comb begin
		if (!config_done) begin
			case (word_index)
				3'd0: next_word = matrix_game_pkg::CONFIG_SHUTDOWN;
				3'd1: next_word = matrix_game_pkg::CONFIG_SCAN_LIMIT;
				3'd2: next_word = matrix_game_pkg::CONFIG_DECODE;
				3'd3: next_word = matrix_game_pkg::CONFIG_INTENSITY;
				default: next_word = matrix_game_pkg::CONFIG_TEST;
			endcase
		end else begin
			next_word = {4'h0, digit_addr, column};
		end
	end

	// ##########################################################
	// Serial shifter and sequencing
	// ##########################################################
	assign half_done =
		(half_count == $bits(half_count)'(matrix_game_pkg::SERIAL_HALF_PERIOD - 1));
	assign gap_done = (gap_count == $bits(gap_count)'(matrix_game_pkg::GAP_CYCLES - 1));
	// MSB first, zeros shift in so the line idles low
	assign max7219_din = shifter[15];

	always_ff @(posedge clock_50) begin
		if (reset) begin
			state <= matrix_game_pkg::max_gap;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b0;
			shifter <= '0;
			config_done <= 1'b0;
			word_index <= '0;
			bit_count <= '0;
			half_count <= '0;
			gap_count <= '0;
		end else if (state == matrix_game_pkg::max_gap) begin
			gap_count <= gap_count + 1'b1;
			if (gap_done) begin
				// Chip select falls with the first bit already on the line
				gap_count <= '0;
				max7219_ncs <= 1'b0;
				shifter <= next_word;
				state <= config_done ? matrix_game_pkg::max_scan : matrix_game_pkg::max_config;
			end
		end else begin
			half_count <= half_count + 1'b1;
			if (half_done) begin
				half_count <= '0;
				max7219_clk <= !max7219_clk;
				// Data moves only on the falling edge
				if (max7219_clk) begin
					shifter <= {shifter[14:0], 1'b0};
					bit_count <= bit_count + 1'b1;
					if (bit_count == 4'd15) begin
						// Word latched by the rising chip select
						max7219_ncs <= 1'b1;
						state <= matrix_game_pkg::max_gap;
						word_index <= word_index + 1'b1;
						if (state == matrix_game_pkg::max_config &&
							word_index == 3'(matrix_game_pkg::CONFIG_WORDS - 1)) begin
							config_done <= 1'b1;
							word_index <= '0;
						end
					end
				end
			end
		end
	end

	// Frame captured once per pass, at the load of digit 1
	always_ff @(posedge clock_50) begin
		if (state == matrix_game_pkg::max_gap && gap_done && config_done &&
			word_index == '0) begin
			snapshot <= live;
		end
	end

endmodule

// ==== source/obstacle_source.sv ====
/* Shared LFSR obstacle generator with the playability rule */
`timescale 1ns/1ps

module obstacle_source (
	input  logic clock_50,
	input  logic reset,
	input  logic step,
	output matrix_game_pkg::row_t new_row
);

	logic [15:0] lfsr;
	logic feedback;

	// Never a fully blocked half, so one cell stays open
	function automatic matrix_game_pkg::half_row_t playable(
		input matrix_game_pkg::half_row_t half);
		if (half == 4'b1111) begin
			return 4'b1110;
		end
		return half;
	endfunction

	// Taps 16, 14, 13, 11
	assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

	always_ff @(posedge clock_50) begin
		if (reset) begin
			lfsr <= matrix_game_pkg::LFSR_SEED;
		end else if (step) begin
			lfsr <= {lfsr[14:0], feedback};
		end
	end

	// Left half from bits 7..4, right half from bits 3..0
	assign new_row = {playable(lfsr[7:4]), playable(lfsr[3:0])};

endmodule

// ==== source/player_position.sv ====
/* One player's one-hot marker: start load, left and right moves */
`timescale 1ns/1ps

module player_position (
	input  logic clock_50,
	input  logic reset,
	input  logic start_pulse,
	input  logic running,
	input  logic move_left,
	input  logic move_right,
	output matrix_game_pkg::half_row_t position
);

	// Exactly one button pressed, the other released
	logic single_move;

	assign single_move = move_left ^ move_right;

	always_ff @(posedge clock_50) begin
		if (reset || start_pulse) begin
			// Back to the start cell
			position <= matrix_game_pkg::START_POSITION;
		end else if (running && single_move) begin
			// Left moves toward the MSB, stops at the edge
			if (move_left && !position[3]) begin
				position <= position << 1;
			end
			// Right moves toward the LSB, stops at the edge
			if (move_right && !position[0]) begin
				position <= position >> 1;
			end
		end
	end

endmodule

// ==== source/step_timer.sv ====
/* Game state machine and step prescaler */
`timescale 1ns/1ps

module step_timer (
	input  logic clock_50,
	input  logic reset,
	input  logic start_button,
	output logic start_pulse,
	output logic running,
	output logic step
);

	matrix_game_pkg::game_state_t state;
	logic [$clog2(matrix_game_pkg::STEP_CYCLES)-1:0] prescaler;
	logic prescaler_full;

	// Buttons arrive clean, so start acts on each high cycle
	assign start_pulse = start_button;
	assign running = (state == matrix_game_pkg::game_running);

	assign prescaler_full =
		(prescaler == $bits(prescaler)'(matrix_game_pkg::STEP_CYCLES - 1));
	// A start in the same cycle wins over the step
	assign step = running && prescaler_full && !start_pulse;

	always_ff @(posedge clock_50) begin
		if (reset) begin
			state <= matrix_game_pkg::game_idle;
			prescaler <= '0;
		end else if (start_pulse) begin
			// Enter or restart the game, count from zero again
			state <= matrix_game_pkg::game_running;
			prescaler <= '0;
		end else if (running) begin
			prescaler <= prescaler_full ? '0 : prescaler + 1'b1;
		end
	end

endmodule

// ==== testbench/max7219_properties.sv ====
/* Serial protocol assertions for the MAX7219 driver */
`timescale 1ns/1ps

module max7219_properties (
	input logic clock_50,
	input logic reset,
	input logic max7219_din,
	input logic max7219_ncs,
	input logic max7219_clk
);

	// Serial clock parks low between words
	clock_low_when_deselected: assert property (
		@(posedge clock_50) disable iff (reset) max7219_ncs |-> !max7219_clk)
		else $error("max7219 clock is high while chip select is high");

	// Data may only move while the serial clock is low
	data_stable_while_clock_high: assert property (
		@(posedge clock_50) disable iff (reset) max7219_clk |-> $stable(max7219_din))
		else $error("max7219 data changed while the serial clock was high");

	// Link comes out of reset deselected
	deselected_after_reset: assert property (
		@(posedge clock_50) reset |=> max7219_ncs)
		else $error("max7219 chip select is low in the cycle after reset");

endmodule

// ==== testbench/tb_clock.sv ====
/* Testbench clock of 10 ns and a 5-cycle synchronous reset */
`timescale 1ns/1ps

module tb_clock (
	output logic clock_50,
	output logic reset
);

	initial begin
		clock_50 = 1'b0;
		forever #5 clock_50 = ~clock_50;
	end

	// Reset held high for the first five rising edges
	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clock_50);
		reset <= 1'b0;
	end

endmodule

// ==== testbench/tb_frame_checker.sv ====
/* Decodes MAX7219 serial words into frames and compares them
   with the player model, the configuration table and the game rules */
`timescale 1ns/1ps

module tb_frame_checker (
	input  logic clock_50,
	input  logic reset,
	input  logic max7219_din,
	input  logic max7219_ncs,
	input  logic max7219_clk,
	input  matrix_game_pkg::half_row_t model_pos_l,
	input  matrix_game_pkg::half_row_t model_pos_r,
	input  logic model_running,
	input  logic model_stable,
	input  logic [7:0] start_count,
	output int mismatch_count,
	output int protocol_count,
	output int frame_count
);

	logic prev_clk;
	logic prev_ncs;
	matrix_game_pkg::max_word_t shift_word;
	int bit_count;
	int word_count;
	logic [7:0] digit_mask;
	matrix_game_pkg::row_t frame_rows [8];
	matrix_game_pkg::row_t last_rows [8];
	logic last_valid;
	logic [7:0] last_start;
	logic [7:0] cleared_start;
	// Model state at the start of the word in flight, and of the current frame
	logic pend_stable;
	logic pend_running;
	matrix_game_pkg::half_row_t pend_l;
	matrix_game_pkg::half_row_t pend_r;
	logic [7:0] pend_start;
	logic frame_stable;
	logic frame_running;
	matrix_game_pkg::half_row_t frame_l;
	matrix_game_pkg::half_row_t frame_r;
	logic [7:0] frame_start;

	// Table order as the display needs it after power-up
	function automatic matrix_game_pkg::max_word_t config_word(input int index);
		case (index)
			0: return matrix_game_pkg::CONFIG_SHUTDOWN;
			1: return matrix_game_pkg::CONFIG_SCAN_LIMIT;
			2: return matrix_game_pkg::CONFIG_DECODE;
			3: return matrix_game_pkg::CONFIG_INTENSITY;
			default: return matrix_game_pkg::CONFIG_TEST;
		endcase
	endfunction

	task automatic compare_row(input string test, input matrix_game_pkg::row_t expected,
		input matrix_game_pkg::row_t actual);
		if (actual !== expected) begin
			$display("mismatch in %s: expected %h, actual %h", test, expected, actual);
			mismatch_count++;
		end
	endtask

	// ##########################################################
	// Frame checks
	// ##########################################################
	task automatic check_frame();
		logic [47:0] now_rows;
		logic [47:0] old_same;
		logic [47:0] old_shift;
		matrix_game_pkg::row_t players;
		players = {frame_l, frame_r};
		frame_count++;
		// Top row never blocks a whole half
		if (frame_running && (frame_rows[7][7:4] == 4'hF || frame_rows[7][3:0] == 4'hF)) begin
			$display("mismatch in playability: expected no full half, actual row 7 %h",
				frame_rows[7]);
			mismatch_count++;
		end
		if (!frame_running) begin
			// Moves are ignored while idle, so every idle frame is exact
			compare_row("player_movement_idle", players, frame_rows[0]);
			for (int r = 1; r < 8; r++) begin
				compare_row("idle_frame", 8'h00, frame_rows[r]);
			end
		end else if (frame_stable && frame_start != cleared_start) begin
			// First settled frame after a start shows an empty field
			compare_row("start_clear", {2{matrix_game_pkg::START_POSITION}}, frame_rows[0]);
			for (int r = 1; r < 8; r++) begin
				compare_row("start_clear", 8'h00, frame_rows[r]);
			end
			cleared_start = frame_start;
		end else if (frame_stable) begin
			if ((frame_rows[0] & players) != players) begin
				$display("mismatch in player_movement: expected bits %h, actual %h",
					players, frame_rows[0]);
				mismatch_count++;
			end
			if (last_valid && last_start == frame_start) begin
				for (int k = 1; k < 7; k++) begin
					now_rows[(k - 1) * 8 +: 8] = frame_rows[k];
					old_same[(k - 1) * 8 +: 8] = last_rows[k];
					old_shift[(k - 1) * 8 +: 8] = last_rows[k + 1];
				end
				if (now_rows != old_same && now_rows != old_shift) begin
					$display("mismatch in scrolling: expected %h or %h, actual %h",
						old_same, old_shift, now_rows);
					mismatch_count++;
				end
			end
		end
		last_rows = frame_rows;
		last_valid = frame_stable && frame_running;
		last_start = frame_start;
	endtask

	// ##########################################################
	// Word decoding
	// ##########################################################
	task automatic handle_word(input matrix_game_pkg::max_word_t word);
		int addr;
		addr = int'(word[11:8]);
		if (word_count < matrix_game_pkg::CONFIG_WORDS) begin
			if (word !== config_word(word_count)) begin
				$display("mismatch in config_word_%0d: expected %h, actual %h",
					word_count, config_word(word_count), word);
				mismatch_count++;
			end
		end else if (word[15:12] != 4'h0 || addr < 1 || addr > 8) begin
			$display("protocol failure: display word %h has an address outside 1..8", word);
			protocol_count++;
		end else begin
			if (addr == 1) begin
				digit_mask = 8'h00;
				frame_stable = pend_stable;
				frame_running = pend_running;
				frame_l = pend_l;
				frame_r = pend_r;
				frame_start = pend_start;
			end
			// Digit d holds column 8-d, data bit 7 is row 0
			for (int r = 0; r < 8; r++) begin
				frame_rows[r][8 - addr] = word[7 - r];
			end
			digit_mask[addr - 1] = 1'b1;
			if (addr == 8) begin
				if (digit_mask == 8'hFF) begin
					check_frame();
				end else begin
					$display("protocol failure: digit 8 arrived before the other digits of its frame");
					protocol_count++;
				end
			end
		end
		word_count++;
	endtask

	initial begin
		mismatch_count = 0;
		protocol_count = 0;
		frame_count = 0;
		word_count = 0;
		last_valid = 1'b0;
		last_start = 8'h00;
		cleared_start = 8'h00;
		digit_mask = 8'h00;
	end

	// Inputs seen here are the values left by the previous edge
	always @(posedge clock_50) begin
		if (reset) begin
			prev_clk = 1'b0;
			prev_ncs = 1'b1;
			bit_count = 0;
		end else begin
			if (prev_ncs && !max7219_ncs) begin
				// Word starts, the driver took its snapshot one edge ago
				bit_count = 0;
				pend_stable = model_stable;
				pend_running = model_running;
				pend_l = model_pos_l;
				pend_r = model_pos_r;
				pend_start = start_count;
			end
			if (!prev_clk && max7219_clk) begin
				shift_word = {shift_word[14:0], max7219_din};
				bit_count++;
			end
			if (!prev_ncs && max7219_ncs) begin
				if (bit_count != 16) begin
					$display("protocol failure: word ended after %0d clock edges instead of 16",
						bit_count);
					protocol_count++;
				end else begin
					handle_word(shift_word);
				end
			end
			prev_clk = max7219_clk;
			prev_ncs = max7219_ncs;
		end
	end

endmodule

// ==== testbench/tb_matrix_game.sv ====
/* Testbench top: clock, DUT, random button actions, player model,
   frame checker, bound protocol assertions and the run verdict */
`timescale 1ns/1ps

module tb_matrix_game;

	localparam int ACTION_COUNT = 60;
	// Quiet time after each action, longer than two scan passes
	localparam int WAIT_CYCLES = 1200;
	localparam int TIMEOUT_CYCLES = ACTION_COUNT * 1300 + 2000;
	// Makes sure the running game is reached early
	localparam int FORCED_START_ACTION = 8;

	logic clock_50;
	logic reset;
	logic start_button;
	logic left_button_l;
	logic right_button_l;
	logic left_button_r;
	logic right_button_r;
	logic max7219_din;
	logic max7219_ncs;
	logic max7219_clk;
	matrix_game_pkg::half_row_t model_pos_l;
	matrix_game_pkg::half_row_t model_pos_r;
	logic model_running;
	logic model_stable;
	logic [7:0] start_count;
	int mismatch_count;
	int protocol_count;
	int frame_count;
	integer seed;
	logic result_printed;

	tb_clock i_clock (
		.clock_50(clock_50),
		.reset   (reset)
	);

	matrix_game_top i_dut (
		.clock_50      (clock_50),
		.reset         (reset),
		.start_button  (start_button),
		.left_button_l (left_button_l),
		.right_button_l(right_button_l),
		.left_button_r (left_button_r),
		.right_button_r(right_button_r),
		.max7219_din   (max7219_din),
		.max7219_ncs   (max7219_ncs),
		.max7219_clk   (max7219_clk)
	);

	tb_frame_checker i_checker (
		.clock_50      (clock_50),
		.reset         (reset),
		.max7219_din   (max7219_din),
		.max7219_ncs   (max7219_ncs),
		.max7219_clk   (max7219_clk),
		.model_pos_l   (model_pos_l),
		.model_pos_r   (model_pos_r),
		.model_running (model_running),
		.model_stable  (model_stable),
		.start_count   (start_count),
		.mismatch_count(mismatch_count),
		.protocol_count(protocol_count),
		.frame_count   (frame_count)
	);

	bind max7219_driver max7219_properties i_properties (
		.clock_50   (clock_50),
		.reset      (reset),
		.max7219_din(max7219_din),
		.max7219_ncs(max7219_ncs),
		.max7219_clk(max7219_clk)
	);

	// Marker moves one cell per press while running, stops at the nibble edges
	function automatic matrix_game_pkg::half_row_t moved_position(
		input matrix_game_pkg::half_row_t pos, input logic left, input logic right,
		input logic active);
		if (active && left && !right && pos != 4'b1000) begin
			return pos << 1;
		end
		if (active && right && !left && pos != 4'b0001) begin
			return pos >> 1;
		end
		return pos;
	endfunction

	task automatic close_run(input logic timed_out);
		int error_total;
		error_total = mismatch_count + protocol_count;
		if (timed_out) begin
			$display("run stopped: cycle limit of %0d reached", TIMEOUT_CYCLES);
		end
		if (frame_count == 0) begin
			$display("no complete display frame was decoded");
		end
		$display("errors: %0d mismatches, %0d protocol failures, %0d frames checked",
			mismatch_count, protocol_count, frame_count);
		result_printed = 1'b1;
		if (!timed_out && error_total == 0 && frame_count > 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	endtask

	// ##########################################################
	// Stimulus and player model
	// ##########################################################
	initial begin : stimulus
		logic [3:0] choice;
		logic press_start;
		logic [3:0] press;
		start_button = 1'b0;
		left_button_l = 1'b0;
		right_button_l = 1'b0;
		left_button_r = 1'b0;
		right_button_r = 1'b0;
		model_pos_l = matrix_game_pkg::START_POSITION;
		model_pos_r = matrix_game_pkg::START_POSITION;
		model_running = 1'b0;
		model_stable = 1'b1;
		start_count = 8'h00;
		result_printed = 1'b0;
		seed = 32'h4532ebeb;
		@(posedge clock_50);
		while (reset) begin
			@(posedge clock_50);
		end
		for (int n = 0; n < ACTION_COUNT; n++) begin
			// Start on one value in sixteen, otherwise one move button
			choice = 4'($random(seed));
			press_start = (choice == 4'd0) || (n == FORCED_START_ACTION);
			press = press_start ? 4'b0000 : 4'b0001 << choice[1:0];
			start_button <= press_start;
			left_button_l <= press[0];
			right_button_l <= press[1];
			left_button_r <= press[2];
			right_button_r <= press[3];
			model_stable <= 1'b0;
			if (press_start) begin
				model_pos_l <= matrix_game_pkg::START_POSITION;
				model_pos_r <= matrix_game_pkg::START_POSITION;
				model_running <= 1'b1;
				start_count <= start_count + 8'd1;
			end else begin
				model_pos_l <= moved_position(model_pos_l, press[0], press[1], model_running);
				model_pos_r <= moved_position(model_pos_r, press[2], press[3], model_running);
			end
			@(posedge clock_50);
			start_button <= 1'b0;
			left_button_l <= 1'b0;
			right_button_l <= 1'b0;
			left_button_r <= 1'b0;
			right_button_r <= 1'b0;
			// Frames captured from here on show the new positions
			@(posedge clock_50);
			model_stable <= 1'b1;
			repeat (WAIT_CYCLES - 2) @(posedge clock_50);
		end
		close_run(1'b0);
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clock_50);
			cycles++;
		end
		close_run(1'b1);
	end

	// Run ended by an assertion or the simulator without a verdict
	final begin
		if (!result_printed) begin
			$display("TESTBENCH FAILED");
		end
	end

endmodule

// ==== verilog.f ====
source/matrix_game_pkg.sv
source/player_position.sv
source/step_timer.sv
source/obstacle_source.sv
source/background_scroller.sv
source/max7219_driver.sv
source/matrix_game_top.sv
testbench/tb_clock.sv
testbench/max7219_properties.sv
testbench/tb_frame_checker.sv
testbench/tb_matrix_game.sv
